// ==== soc_pkg.sv ====
package soc_pkg;

	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int STRB_W = DATA_W / 8;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;
	typedef logic [STRB_W-1:0] strb_t;
	typedef logic [1:0]        resp_t;

	localparam resp_t RESP_OKAY   = 2'd0;
	localparam resp_t RESP_DECERR = 2'd3;

	localparam int NO_MASTERS = 2;
	localparam int NO_MEMS    = 2;
	localparam int NO_TARGETS = NO_MEMS + 1; // sys_ctrl is the last target.
	localparam int NO_CORES   = 2;

	localparam addr_t MEM_BASE   = 32'h1000_0000;
	localparam addr_t MEM_STRIDE = 32'h0100_0000;
	localparam addr_t CTRL_BASE  = 32'h2000_0000;
	localparam addr_t CTRL_END   = 32'h3000_0000;

	localparam int MEM_WORDS = 256;

	localparam addr_t REG_SCRATCH = 32'h0;
	localparam addr_t REG_BOOT    = 32'h4;
	localparam addr_t REG_SRST    = 32'h8;

	typedef enum logic [2:0] {
		RUN,
		PAUSE_PERIPH,
		PAUSE_XBAR,
		PAUSED,
		RESUME_XBAR,
		RESUME_PERIPH
	} pause_state_e;

	function automatic data_t apply_strb(data_t old_word, data_t new_word, strb_t strb);
		data_t merged;
		merged = old_word;
		for (int b = 0; b < STRB_W; b++) begin
			if (strb[b]) begin
				merged[8*b +: 8] = new_word[8*b +: 8];
			end
		end
		return merged;
	endfunction

endpackage

// ==== axil_if.sv ====
`timescale 1ns/1ps

interface axil_if;

	soc_pkg::addr_t aw_addr;
	logic           aw_valid;
	logic           aw_ready;

	soc_pkg::data_t w_data;
	soc_pkg::strb_t w_strb;
	logic           w_valid;
	logic           w_ready;

	soc_pkg::resp_t b_resp;
	logic           b_valid;
	logic           b_ready;

	soc_pkg::addr_t ar_addr;
	logic           ar_valid;
	logic           ar_ready;

	soc_pkg::data_t r_data;
	soc_pkg::resp_t r_resp;
	logic           r_valid;
	logic           r_ready;

	modport master (
		output aw_addr, aw_valid, input aw_ready,
		output w_data, w_strb, w_valid, input w_ready,
		input b_resp, b_valid, output b_ready,
		output ar_addr, ar_valid, input ar_ready,
		input r_data, r_resp, r_valid, output r_ready
	);

	modport slave (
		input aw_addr, aw_valid, output aw_ready,
		input w_data, w_strb, w_valid, output w_ready,
		output b_resp, b_valid, input b_ready,
		input ar_addr, ar_valid, output ar_ready,
		output r_data, r_resp, r_valid, input r_ready
	);

endinterface

// ==== pause_seq.sv ====
`timescale 1ns/1ps

module pause_seq (
	input  logic clk,
	input  logic rst,

	input  logic pause_req,
	output logic pause_ack,

	output logic periph_pause_req,
	input  logic periph_pause_ack,

	output logic xbar_pause_req,
	input  logic xbar_pause_ack
);

	soc_pkg::pause_state_e state;
	soc_pkg::pause_state_e state_next;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= soc_pkg::RUN;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			soc_pkg::RUN: begin
				if (pause_req) begin
					state_next = soc_pkg::PAUSE_PERIPH;
				end
			end
			soc_pkg::PAUSE_PERIPH: begin
				if (periph_pause_ack) begin
					state_next = soc_pkg::PAUSE_XBAR;
				end
			end
			soc_pkg::PAUSE_XBAR: begin
				if (xbar_pause_ack) begin
					state_next = soc_pkg::PAUSED;
				end
			end
			soc_pkg::PAUSED: begin
				if (!pause_req) begin
					state_next = soc_pkg::RESUME_XBAR;
				end
			end
			soc_pkg::RESUME_XBAR: begin
				if (!xbar_pause_ack) begin
					state_next = soc_pkg::RESUME_PERIPH;
				end
			end
			soc_pkg::RESUME_PERIPH: begin
				if (!periph_pause_ack) begin
					state_next = soc_pkg::RUN;
				end
			end
			default: state_next = soc_pkg::RUN;
		endcase
	end

	// the peripheral block is paused first and released last.
	assign periph_pause_req = state inside {soc_pkg::PAUSE_PERIPH, soc_pkg::PAUSE_XBAR,
	                                        soc_pkg::PAUSED, soc_pkg::RESUME_XBAR};
	assign xbar_pause_req   = state inside {soc_pkg::PAUSE_XBAR, soc_pkg::PAUSED};
	assign pause_ack        = state inside {soc_pkg::PAUSED, soc_pkg::RESUME_XBAR,
	                                        soc_pkg::RESUME_PERIPH};

endmodule

// ==== axil_xbar.sv ====
`timescale 1ns/1ps

module axil_xbar (
	input  logic  clk,
	input  logic  rst,

	input  logic  pause_req,
	output logic  pause_ack,

	axil_if.slave  mst [soc_pkg::NO_MASTERS],
	axil_if.master tgt [soc_pkg::NO_TARGETS]
);

	typedef logic [$clog2(soc_pkg::NO_MASTERS)-1:0] mst_idx_t;
	typedef logic [$clog2(soc_pkg::NO_TARGETS)-1:0] tgt_idx_t;

	logic           mst_req    [soc_pkg::NO_MASTERS];
	logic           m_ar_valid [soc_pkg::NO_MASTERS];
	logic           m_b_ready  [soc_pkg::NO_MASTERS];
	logic           m_r_ready  [soc_pkg::NO_MASTERS];
	soc_pkg::addr_t m_aw_addr  [soc_pkg::NO_MASTERS];
	soc_pkg::addr_t m_ar_addr  [soc_pkg::NO_MASTERS];
	soc_pkg::data_t m_w_data   [soc_pkg::NO_MASTERS];
	soc_pkg::strb_t m_w_strb   [soc_pkg::NO_MASTERS];

	logic           t_aw_ready [soc_pkg::NO_TARGETS];
	logic           t_w_ready  [soc_pkg::NO_TARGETS];
	logic           t_ar_ready [soc_pkg::NO_TARGETS];
	logic           t_b_valid  [soc_pkg::NO_TARGETS];
	logic           t_r_valid  [soc_pkg::NO_TARGETS];
	soc_pkg::resp_t t_b_resp   [soc_pkg::NO_TARGETS];
	soc_pkg::resp_t t_r_resp   [soc_pkg::NO_TARGETS];
	soc_pkg::data_t t_r_data   [soc_pkg::NO_TARGETS];

	logic act, dec_err, req_aw_v, req_w_v, req_ar_v, rsp_v, rsp_wr;
	mst_idx_t cur_mst, last_mst, gnt_idx;
	tgt_idx_t tgt_sel, dec_idx;
	soc_pkg::addr_t req_addr, sel_addr;
	soc_pkg::data_t req_data, rsp_data;
	soc_pkg::strb_t req_strb;
	soc_pkg::resp_t rsp_resp;
	logic gnt_ok, take, rd_sel, dec_hit, wait_rsp, tgt_rsp, rsp_done;

	for (genvar m = 0; m < soc_pkg::NO_MASTERS; m++) begin : g_mst
		assign m_ar_valid[m] = mst[m].ar_valid;
		assign mst_req[m]    = mst[m].ar_valid || (mst[m].aw_valid && mst[m].w_valid);
		assign m_b_ready[m]  = mst[m].b_ready;
		assign m_r_ready[m]  = mst[m].r_ready;
		assign m_aw_addr[m]  = mst[m].aw_addr;
		assign m_ar_addr[m]  = mst[m].ar_addr;
		assign m_w_data[m]   = mst[m].w_data;
		assign m_w_strb[m]   = mst[m].w_strb;

		assign mst[m].ar_ready = take && rd_sel && gnt_idx == mst_idx_t'(m);
		assign mst[m].aw_ready = take && !rd_sel && gnt_idx == mst_idx_t'(m);
		assign mst[m].w_ready  = take && !rd_sel && gnt_idx == mst_idx_t'(m);
		assign mst[m].b_valid  = rsp_v && rsp_wr && cur_mst == mst_idx_t'(m);
		assign mst[m].b_resp   = rsp_resp;
		assign mst[m].r_valid  = rsp_v && !rsp_wr && cur_mst == mst_idx_t'(m);
		assign mst[m].r_resp   = rsp_resp;
		assign mst[m].r_data   = rsp_data;
	end

	for (genvar t = 0; t < soc_pkg::NO_TARGETS; t++) begin : g_tgt
		assign tgt[t].aw_addr  = req_addr;
		assign tgt[t].aw_valid = req_aw_v && tgt_sel == tgt_idx_t'(t);
		assign tgt[t].w_data   = req_data;
		assign tgt[t].w_strb   = req_strb;
		assign tgt[t].w_valid  = req_w_v && tgt_sel == tgt_idx_t'(t);
		assign tgt[t].ar_addr  = req_addr;
		assign tgt[t].ar_valid = req_ar_v && tgt_sel == tgt_idx_t'(t);
		assign tgt[t].b_ready  = wait_rsp && rsp_wr && tgt_sel == tgt_idx_t'(t);
		assign tgt[t].r_ready  = wait_rsp && !rsp_wr && tgt_sel == tgt_idx_t'(t);

		assign t_aw_ready[t] = tgt[t].aw_ready;
		assign t_w_ready[t]  = tgt[t].w_ready;
		assign t_ar_ready[t] = tgt[t].ar_ready;
		assign t_b_valid[t]  = tgt[t].b_valid;
		assign t_r_valid[t]  = tgt[t].r_valid;
		assign t_b_resp[t]   = tgt[t].b_resp;
		assign t_r_resp[t]   = tgt[t].r_resp;
		assign t_r_data[t]   = tgt[t].r_data;
	end

	// search starts at the master after the last one granted.
	always_comb begin
		gnt_ok  = 1'b0;
		gnt_idx = last_mst;
		for (int k = 1; k <= soc_pkg::NO_MASTERS; k++) begin
			if (!gnt_ok && mst_req[(int'(last_mst) + k) % soc_pkg::NO_MASTERS]) begin
				gnt_ok  = 1'b1;
				gnt_idx = mst_idx_t'((int'(last_mst) + k) % soc_pkg::NO_MASTERS);
			end
		end
	end

	assign take     = gnt_ok && !act && !pause_req;
	assign rd_sel   = m_ar_valid[gnt_idx]; // reads win over writes.
	assign sel_addr = rd_sel ? m_ar_addr[gnt_idx] : m_aw_addr[gnt_idx];

	always_comb begin
		dec_hit = 1'b0;
		dec_idx = '0;
		for (int i = 0; i < soc_pkg::NO_MEMS; i++) begin
			if (sel_addr >= soc_pkg::MEM_BASE + soc_pkg::addr_t'(i) * soc_pkg::MEM_STRIDE &&
			    sel_addr < soc_pkg::MEM_BASE + soc_pkg::addr_t'(i + 1) * soc_pkg::MEM_STRIDE) begin
				dec_hit = 1'b1;
				dec_idx = tgt_idx_t'(i);
			end
		end
		if (sel_addr >= soc_pkg::CTRL_BASE && sel_addr < soc_pkg::CTRL_END) begin
			dec_hit = 1'b1;
			dec_idx = tgt_idx_t'(soc_pkg::NO_TARGETS - 1);
		end
	end

	assign wait_rsp = act && !dec_err && !rsp_v && !req_aw_v && !req_w_v && !req_ar_v;
	assign tgt_rsp  = wait_rsp && (rsp_wr ? t_b_valid[tgt_sel] : t_r_valid[tgt_sel]);
	assign rsp_done = rsp_v && (rsp_wr ? m_b_ready[cur_mst] : m_r_ready[cur_mst]);

	always_ff @(posedge clk) begin
		if (rst) begin
			act       <= 1'b0;
			dec_err   <= 1'b0;
			req_aw_v  <= 1'b0;
			req_w_v   <= 1'b0;
			req_ar_v  <= 1'b0;
			rsp_v     <= 1'b0;
			last_mst  <= '0;
			pause_ack <= 1'b0;
		end else begin
			pause_ack <= pause_req && !act;
			if (take) begin
				act      <= 1'b1;
				last_mst <= gnt_idx;
				dec_err  <= !dec_hit; // answered locally, the targets never see it.
				req_ar_v <= dec_hit && rd_sel;
				req_aw_v <= dec_hit && !rd_sel;
				req_w_v  <= dec_hit && !rd_sel;
			end else begin
				if (req_aw_v && t_aw_ready[tgt_sel]) begin
					req_aw_v <= 1'b0;
				end
				if (req_w_v && t_w_ready[tgt_sel]) begin
					req_w_v <= 1'b0;
				end
				if (req_ar_v && t_ar_ready[tgt_sel]) begin
					req_ar_v <= 1'b0;
				end
				if (dec_err) begin
					dec_err <= 1'b0;
					rsp_v   <= 1'b1;
				end
				if (tgt_rsp) begin
					rsp_v <= 1'b1;
				end
				if (rsp_done) begin
					rsp_v <= 1'b0;
					act   <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			cur_mst  <= gnt_idx;
			rsp_wr   <= !rd_sel;
			tgt_sel  <= dec_idx;
			req_addr <= sel_addr;
			req_data <= m_w_data[gnt_idx];
			req_strb <= m_w_strb[gnt_idx];
		end
		if (dec_err) begin
			rsp_resp <= soc_pkg::RESP_DECERR;
			rsp_data <= '0;
		end else if (tgt_rsp) begin
			rsp_resp <= rsp_wr ? t_b_resp[tgt_sel] : t_r_resp[tgt_sel];
			rsp_data <= rsp_wr ? '0 : t_r_data[tgt_sel];
		end
	end

endmodule

// ==== axil_sram.sv ====
`timescale 1ns/1ps

module axil_sram (
	input logic   clk,
	input logic   rst,
	axil_if.slave bus
);

	localparam int IDX_W = $clog2(soc_pkg::MEM_WORDS);

	soc_pkg::data_t mem [soc_pkg::MEM_WORDS];

	logic busy;
	logic rd_take;
	logic wr_take;
	logic [IDX_W-1:0] rd_idx;
	logic [IDX_W-1:0] wr_idx;

	assign busy    = bus.b_valid || bus.r_valid; // one request at a time.
	assign rd_take = bus.ar_valid && !busy;
	assign wr_take = bus.aw_valid && bus.w_valid && !bus.ar_valid && !busy;

	assign bus.ar_ready = rd_take;
	assign bus.aw_ready = wr_take;
	assign bus.w_ready  = wr_take;

	// word index, so the memory repeats inside its window.
	assign rd_idx = bus.ar_addr[IDX_W+1:2];
	assign wr_idx = bus.aw_addr[IDX_W+1:2];

	assign bus.b_resp = soc_pkg::RESP_OKAY;
	assign bus.r_resp = soc_pkg::RESP_OKAY;

	always_ff @(posedge clk) begin
		if (rst) begin
			bus.b_valid <= 1'b0;
			bus.r_valid <= 1'b0;
		end else begin
			if (wr_take) begin
				bus.b_valid <= 1'b1;
			end else if (bus.b_ready) begin
				bus.b_valid <= 1'b0;
			end
			if (rd_take) begin
				bus.r_valid <= 1'b1;
			end else if (bus.r_ready) begin
				bus.r_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_take) begin
			mem[wr_idx] <= soc_pkg::apply_strb(mem[wr_idx], bus.w_data, bus.w_strb);
		end
		if (rd_take) begin
			bus.r_data <= mem[rd_idx];
		end
	end

endmodule

// ==== sys_ctrl.sv ====
`timescale 1ns/1ps

module sys_ctrl (
	input  logic                        clk,
	input  logic                        rst,
	axil_if.slave                       bus,

	input  logic                        pause_req,
	output logic                        pause_ack,

	input  soc_pkg::addr_t              rst_boot_addr,
	output soc_pkg::addr_t              boot_addr,
	output logic [soc_pkg::NO_CORES-1:0] core_srst
);

	soc_pkg::data_t scratch;
	soc_pkg::data_t rd_word;
	soc_pkg::data_t srst_word;
	soc_pkg::addr_t rd_off;
	soc_pkg::addr_t wr_off;

	logic busy;
	logic rd_take;
	logic wr_take;

	assign busy    = bus.b_valid || bus.r_valid;
	assign rd_take = bus.ar_valid && !busy && !pause_req;
	assign wr_take = bus.aw_valid && bus.w_valid && !bus.ar_valid && !busy && !pause_req;

	assign bus.ar_ready = rd_take;
	assign bus.aw_ready = wr_take;
	assign bus.w_ready  = wr_take;
	assign bus.b_resp   = soc_pkg::RESP_OKAY; // unknown offsets answer OKAY too.
	assign bus.r_resp   = soc_pkg::RESP_OKAY;

	assign rd_off    = bus.ar_addr - soc_pkg::CTRL_BASE;
	assign wr_off    = bus.aw_addr - soc_pkg::CTRL_BASE;
	assign srst_word = soc_pkg::apply_strb(soc_pkg::data_t'(core_srst), bus.w_data, bus.w_strb);

	always_comb begin
		case (rd_off)
			soc_pkg::REG_SCRATCH: rd_word = scratch;
			soc_pkg::REG_BOOT:    rd_word = boot_addr;
			soc_pkg::REG_SRST:    rd_word = soc_pkg::data_t'(core_srst);
			default:              rd_word = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			bus.b_valid <= 1'b0;
			bus.r_valid <= 1'b0;
			pause_ack   <= 1'b0;
			scratch     <= '0;
			boot_addr   <= rst_boot_addr;
			core_srst   <= '0;
		end else begin
			pause_ack <= pause_req && !busy;
			if (wr_take) begin
				bus.b_valid <= 1'b1;
				case (wr_off)
					soc_pkg::REG_SCRATCH: scratch <= soc_pkg::apply_strb(scratch, bus.w_data, bus.w_strb);
					soc_pkg::REG_BOOT:    boot_addr <= soc_pkg::apply_strb(boot_addr, bus.w_data, bus.w_strb);
					soc_pkg::REG_SRST:    core_srst <= srst_word[soc_pkg::NO_CORES-1:0];
					default:              ;
				endcase
			end else if (bus.b_ready) begin
				bus.b_valid <= 1'b0;
			end
			if (rd_take) begin
				bus.r_valid <= 1'b1;
			end else if (bus.r_ready) begin
				bus.r_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rd_take) begin
			bus.r_data <= rd_word;
		end
	end

endmodule

// ==== soc_fabric.sv ====
`timescale 1ns/1ps

module soc_fabric (
	input  logic                         clk,
	input  logic                         rst,

	input  logic                         pause_req,
	output logic                         pause_ack,

	input  soc_pkg::addr_t               rst_boot_addr,
	output soc_pkg::addr_t               boot_addr,
	output logic [soc_pkg::NO_CORES-1:0] core_srst,

	input  soc_pkg::addr_t aw_addr  [soc_pkg::NO_MASTERS],
	input  logic           aw_valid [soc_pkg::NO_MASTERS],
	output logic           aw_ready [soc_pkg::NO_MASTERS],
	input  soc_pkg::data_t w_data   [soc_pkg::NO_MASTERS],
	input  soc_pkg::strb_t w_strb   [soc_pkg::NO_MASTERS],
	input  logic           w_valid  [soc_pkg::NO_MASTERS],
	output logic           w_ready  [soc_pkg::NO_MASTERS],
	output soc_pkg::resp_t b_resp   [soc_pkg::NO_MASTERS],
	output logic           b_valid  [soc_pkg::NO_MASTERS],
	input  logic           b_ready  [soc_pkg::NO_MASTERS],
	input  soc_pkg::addr_t ar_addr  [soc_pkg::NO_MASTERS],
	input  logic           ar_valid [soc_pkg::NO_MASTERS],
	output logic           ar_ready [soc_pkg::NO_MASTERS],
	output soc_pkg::data_t r_data   [soc_pkg::NO_MASTERS],
	output soc_pkg::resp_t r_resp   [soc_pkg::NO_MASTERS],
	output logic           r_valid  [soc_pkg::NO_MASTERS],
	input  logic           r_ready  [soc_pkg::NO_MASTERS]
);

	axil_if mst_bus [soc_pkg::NO_MASTERS] ();
	axil_if tgt_bus [soc_pkg::NO_TARGETS] ();

	logic periph_pause_req;
	logic periph_pause_ack;
	logic xbar_pause_req;
	logic xbar_pause_ack;

	for (genvar m = 0; m < soc_pkg::NO_MASTERS; m++) begin : g_mst
		assign mst_bus[m].aw_addr  = aw_addr[m];
		assign mst_bus[m].aw_valid = aw_valid[m];
		assign aw_ready[m]         = mst_bus[m].aw_ready;
		assign mst_bus[m].w_data   = w_data[m];
		assign mst_bus[m].w_strb   = w_strb[m];
		assign mst_bus[m].w_valid  = w_valid[m];
		assign w_ready[m]          = mst_bus[m].w_ready;
		assign b_resp[m]           = mst_bus[m].b_resp;
		assign b_valid[m]          = mst_bus[m].b_valid;
		assign mst_bus[m].b_ready  = b_ready[m];
		assign mst_bus[m].ar_addr  = ar_addr[m];
		assign mst_bus[m].ar_valid = ar_valid[m];
		assign ar_ready[m]         = mst_bus[m].ar_ready;
		assign r_data[m]           = mst_bus[m].r_data;
		assign r_resp[m]           = mst_bus[m].r_resp;
		assign r_valid[m]          = mst_bus[m].r_valid;
		assign mst_bus[m].r_ready  = r_ready[m];
	end

	pause_seq i_pause_seq (
		.clk              (clk),
		.rst              (rst),
		.pause_req        (pause_req),
		.pause_ack        (pause_ack),
		.periph_pause_req (periph_pause_req),
		.periph_pause_ack (periph_pause_ack),
		.xbar_pause_req   (xbar_pause_req),
		.xbar_pause_ack   (xbar_pause_ack)
	);

	axil_xbar i_axil_xbar (
		.clk       (clk),
		.rst       (rst),
		.pause_req (xbar_pause_req),
		.pause_ack (xbar_pause_ack),
		.mst       (mst_bus),
		.tgt       (tgt_bus)
	);

	for (genvar i = 0; i < soc_pkg::NO_MEMS; i++) begin : g_mem
		axil_sram i_axil_sram (
			.clk (clk),
			.rst (rst),
			.bus (tgt_bus[i])
		);
	end

	sys_ctrl i_sys_ctrl (
		.clk           (clk),
		.rst           (rst),
		.bus           (tgt_bus[soc_pkg::NO_TARGETS-1]),
		.pause_req     (periph_pause_req),
		.pause_ack     (periph_pause_ack),
		.rst_boot_addr (rst_boot_addr),
		.boot_addr     (boot_addr),
		.core_srst     (core_srst)
	);

endmodule

// ==== tb_soc_fabric.sv ====
`timescale 1ns/1ps

module tb_soc_fabric;

	// about 800 transactions at up to 12 cycles each plus the pause hold, doubled.
	localparam int TIMEOUT_CYCLES = 20000;

	typedef struct packed {
		logic           is_rd;
		soc_pkg::resp_t resp;
		soc_pkg::data_t data;
	} exp_t;

	logic                         clk;
	logic                         rst;
	logic                         pause_req;
	logic                         pause_ack;
	soc_pkg::addr_t               rst_boot_addr;
	soc_pkg::addr_t               boot_addr;
	logic [soc_pkg::NO_CORES-1:0] core_srst;

	soc_pkg::addr_t aw_addr  [soc_pkg::NO_MASTERS];
	logic           aw_valid [soc_pkg::NO_MASTERS];
	logic           aw_ready [soc_pkg::NO_MASTERS];
	soc_pkg::data_t w_data   [soc_pkg::NO_MASTERS];
	soc_pkg::strb_t w_strb   [soc_pkg::NO_MASTERS];
	logic           w_valid  [soc_pkg::NO_MASTERS];
	logic           w_ready  [soc_pkg::NO_MASTERS];
	soc_pkg::resp_t b_resp   [soc_pkg::NO_MASTERS];
	logic           b_valid  [soc_pkg::NO_MASTERS];
	logic           b_ready  [soc_pkg::NO_MASTERS];
	soc_pkg::addr_t ar_addr  [soc_pkg::NO_MASTERS];
	logic           ar_valid [soc_pkg::NO_MASTERS];
	logic           ar_ready [soc_pkg::NO_MASTERS];
	soc_pkg::data_t r_data   [soc_pkg::NO_MASTERS];
	soc_pkg::resp_t r_resp   [soc_pkg::NO_MASTERS];
	logic           r_valid  [soc_pkg::NO_MASTERS];
	logic           r_ready  [soc_pkg::NO_MASTERS];

	soc_pkg::data_t               shadow_mem [soc_pkg::NO_MEMS][soc_pkg::MEM_WORDS];
	soc_pkg::data_t               sh_scratch;
	soc_pkg::data_t               sh_boot;
	logic [soc_pkg::NO_CORES-1:0] sh_srst;

	exp_t exp_q0 [$];
	exp_t exp_q1 [$];
	logic bp_en [soc_pkg::NO_MASTERS];
	int   err_cnt;
	int   chk_cnt;
	int   test_err;
	int   test_chk;
	int   cycle_cnt;

	soc_fabric i_soc_fabric (
		.clk           (clk),
		.rst           (rst),
		.pause_req     (pause_req),
		.pause_ack     (pause_ack),
		.rst_boot_addr (rst_boot_addr),
		.boot_addr     (boot_addr),
		.core_srst     (core_srst),
		.aw_addr       (aw_addr),
		.aw_valid      (aw_valid),
		.aw_ready      (aw_ready),
		.w_data        (w_data),
		.w_strb        (w_strb),
		.w_valid       (w_valid),
		.w_ready       (w_ready),
		.b_resp        (b_resp),
		.b_valid       (b_valid),
		.b_ready       (b_ready),
		.ar_addr       (ar_addr),
		.ar_valid      (ar_valid),
		.ar_ready      (ar_ready),
		.r_data        (r_data),
		.r_resp        (r_resp),
		.r_valid       (r_valid),
		.r_ready       (r_ready)
	);

	always #20 clk = ~clk; // 40 ns period.

	function automatic int decode_target(input soc_pkg::addr_t a);
		soc_pkg::addr_t lo;
		for (int i = 0; i < soc_pkg::NO_MEMS; i++) begin
			lo = soc_pkg::MEM_BASE + soc_pkg::addr_t'(i) * soc_pkg::MEM_STRIDE;
			if (a >= lo && a - lo < soc_pkg::MEM_STRIDE) begin
				return i;
			end
		end
		if (a >= soc_pkg::CTRL_BASE && a < soc_pkg::CTRL_END) begin
			return soc_pkg::NO_TARGETS - 1;
		end
		return -1;
	endfunction

	function automatic soc_pkg::data_t merge_bytes(input soc_pkg::data_t old_word,
		input soc_pkg::data_t new_word, input soc_pkg::strb_t strb);
		soc_pkg::data_t mask;
		mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}}; // one strobe per lane.
		return (old_word & ~mask) | (new_word & mask);
	endfunction

	// expected read response from the shadow model.
	function automatic exp_t ref_read(input soc_pkg::addr_t a);
		exp_t           e;
		int             t;
		soc_pkg::addr_t off;
		e.is_rd = 1'b1;
		e.resp  = soc_pkg::RESP_OKAY;
		e.data  = '0;
		t       = decode_target(a);
		off     = a - soc_pkg::CTRL_BASE;
		if (t < 0) begin
			e.resp = soc_pkg::RESP_DECERR;
		end else if (t < soc_pkg::NO_MEMS) begin
			e.data = shadow_mem[t][a[9:2]];
		end else if (off == soc_pkg::REG_SCRATCH) begin
			e.data = sh_scratch;
		end else if (off == soc_pkg::REG_BOOT) begin
			e.data = sh_boot;
		end else if (off == soc_pkg::REG_SRST) begin
			e.data = soc_pkg::data_t'(sh_srst);
		end
		return e;
	endfunction

	function automatic exp_t model_write(input soc_pkg::addr_t a, input soc_pkg::data_t d,
		input soc_pkg::strb_t s);
		exp_t           e;
		int             t;
		soc_pkg::addr_t off;
		e.is_rd = 1'b0;
		e.resp  = soc_pkg::RESP_OKAY;
		e.data  = '0;
		t       = decode_target(a);
		off     = a - soc_pkg::CTRL_BASE;
		if (t < 0) begin
			e.resp = soc_pkg::RESP_DECERR;
		end else if (t < soc_pkg::NO_MEMS) begin
			shadow_mem[t][a[9:2]] = merge_bytes(shadow_mem[t][a[9:2]], d, s);
		end else if (off == soc_pkg::REG_SCRATCH) begin
			sh_scratch = merge_bytes(sh_scratch, d, s);
		end else if (off == soc_pkg::REG_BOOT) begin
			sh_boot = merge_bytes(sh_boot, d, s);
		end else if (off == soc_pkg::REG_SRST) begin
			if (s[0]) begin
				sh_srst = d[soc_pkg::NO_CORES-1:0]; // the core bits sit in byte lane 0.
			end
		end
		return e;
	endfunction

	function automatic soc_pkg::data_t fill_word(input soc_pkg::addr_t a);
		return {a[7:0], a[31:24], ~a[15:8], a[23:16]} ^ 32'h3c96_a55a;
	endfunction

	// random alias bits above the word index land on the same word.
	function automatic soc_pkg::addr_t mem_addr(input int mem, input int word);
		return soc_pkg::MEM_BASE + soc_pkg::addr_t'(mem) * soc_pkg::MEM_STRIDE
			+ soc_pkg::addr_t'(($urandom & 32'h3fff) << 10) + soc_pkg::addr_t'(word << 2);
	endfunction

	function automatic soc_pkg::addr_t decerr_addr(input int k);
		case (k)
			0:       return $urandom & 32'h0fff_fffc;
			1:       return soc_pkg::MEM_BASE - 4;
			2:       return soc_pkg::MEM_BASE
				+ soc_pkg::addr_t'(soc_pkg::NO_MEMS) * soc_pkg::MEM_STRIDE;
			3:       return 32'h1200_0000 + ($urandom & 32'h0dff_fffc);
			4:       return soc_pkg::CTRL_END;
			5:       return soc_pkg::CTRL_END | ($urandom & 32'hcfff_fffc);
			default: return 32'hffff_fffc;
		endcase
	endfunction

	function automatic logic ready_bit(input int m);
		if (bp_en[m]) begin
			return ($urandom % 3) != 0;
		end
		return 1'b1;
	endfunction

	task automatic push_expect(input int m, input exp_t e);
		if (m == 0) begin
			exp_q0.push_back(e);
		end else begin
			exp_q1.push_back(e);
		end
	endtask

	task automatic bus_write(input int m, input soc_pkg::addr_t a, input soc_pkg::data_t d,
		input soc_pkg::strb_t s);
		logic done;
		push_expect(m, model_write(a, d, s));
		@(posedge clk);
		aw_addr[m]  <= a;
		aw_valid[m] <= 1'b1;
		w_data[m]   <= d;
		w_strb[m]   <= s;
		w_valid[m]  <= 1'b1;
		do @(posedge clk); while (!(aw_ready[m] && w_ready[m]));
		aw_valid[m] <= 1'b0;
		w_valid[m]  <= 1'b0;
		b_ready[m]  <= ready_bit(m);
		done = 1'b0;
		while (!done) begin
			@(posedge clk);
			done = b_valid[m] && b_ready[m];
			b_ready[m] <= done ? 1'b0 : ready_bit(m);
		end
	endtask

	task automatic bus_read(input int m, input soc_pkg::addr_t a);
		logic done;
		push_expect(m, ref_read(a));
		@(posedge clk);
		ar_addr[m]  <= a;
		ar_valid[m] <= 1'b1;
		do @(posedge clk); while (!ar_ready[m]);
		ar_valid[m] <= 1'b0;
		r_ready[m]  <= ready_bit(m);
		done = 1'b0;
		while (!done) begin
			@(posedge clk);
			done = r_valid[m] && r_ready[m];
			r_ready[m] <= done ? 1'b0 : ready_bit(m);
		end
	endtask

	// each master owns the words whose index parity equals its number.
	task automatic random_traffic(input int m, input int n);
		soc_pkg::addr_t a;
		for (int i = 0; i < n; i++) begin
			if ($urandom % 8 == 0) begin
				a = decerr_addr($urandom % 7);
			end else begin
				a = mem_addr($urandom % 2, (($urandom % 128) * 2) + m);
			end
			if ($urandom % 2) begin
				bus_write(m, a, $urandom, soc_pkg::strb_t'($urandom));
			end else begin
				bus_read(m, a);
			end
		end
	endtask

	task automatic check_rsp(input int m, input logic is_rd, input soc_pkg::resp_t resp,
		input soc_pkg::data_t data);
		exp_t  e;
		logic  empty;
		string ch;
		empty = 1'b0;
		ch    = is_rd ? "r" : "b";
		if (m == 0) begin
			if (exp_q0.size() == 0) begin
				empty = 1'b1;
			end else begin
				e = exp_q0.pop_front();
			end
		end else begin
			if (exp_q1.size() == 0) begin
				empty = 1'b1;
			end else begin
				e = exp_q1.pop_front();
			end
		end
		chk_cnt++;
		if (empty) begin
			$display("master %0d returned a response with nothing outstanding", m);
			err_cnt++;
		end else if (e.is_rd != is_rd) begin
			$display("master %0d returned a %s response where the other kind was due", m, ch);
			err_cnt++;
		end else begin
			if (resp !== e.resp) begin
				$display("Fail m%0d %s_resp: got %h expected %h", m, ch, resp, e.resp);
				err_cnt++;
			end
			if (is_rd && data !== e.data) begin
				$display("Fail m%0d r_data: got %h expected %h", m, data, e.data);
				err_cnt++;
			end
		end
	endtask

	task automatic check_val(input string name, input soc_pkg::data_t got,
		input soc_pkg::data_t want);
		chk_cnt++;
		if (got !== want) begin
			$display("Fail %s: got %h expected %h", name, got, want);
			err_cnt++;
		end
	endtask

	task automatic report_test(input string name);
		$display("test %0s: %0d checks, %0d errors", name, chk_cnt - test_chk, err_cnt - test_err);
		test_chk = chk_cnt;
		test_err = err_cnt;
	endtask

	// values read here are the ones from just before the edge.
	always @(posedge clk) begin
		for (int m = 0; m < soc_pkg::NO_MASTERS; m++) begin
			if (b_valid[m] === 1'b1 && b_ready[m] === 1'b1) begin
				check_rsp(m, 1'b0, b_resp[m], '0);
			end
			if (r_valid[m] === 1'b1 && r_ready[m] === 1'b1) begin
				check_rsp(m, 1'b1, r_resp[m], r_data[m]);
			end
		end
	end

	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		int             m;
		int             cnt;
		soc_pkg::addr_t a;
		rst_boot_addr = $urandom(32'h7f5d_ef44) & 32'hffff_fffc; // seeds the generator.
		clk           = 1'b0;
		rst           = 1'b1;
		pause_req     = 1'b0;
		for (int i = 0; i < soc_pkg::NO_MASTERS; i++) begin
			aw_addr[i]  = '0;
			aw_valid[i] = 1'b0;
			w_data[i]   = '0;
			w_strb[i]   = '0;
			w_valid[i]  = 1'b0;
			b_ready[i]  = 1'b0;
			ar_addr[i]  = '0;
			ar_valid[i] = 1'b0;
			r_ready[i]  = 1'b0;
			bp_en[i]    = 1'b0;
		end
		err_cnt    = 0;
		chk_cnt    = 0;
		test_err   = 0;
		test_chk   = 0;
		sh_scratch = '0;
		sh_srst    = '0;
		sh_boot    = rst_boot_addr;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);

		for (int i = 0; i < soc_pkg::NO_MEMS; i++) begin
			for (int w = 0; w < soc_pkg::MEM_WORDS; w++) begin
				a = mem_addr(i, w);
				bus_write(0, a, fill_word(a), '1);
			end
		end
		report_test("fill");

		for (int i = 0; i < 40; i++) begin
			m   = i % 2;
			cnt = $urandom % soc_pkg::MEM_WORDS;
			a   = mem_addr(i % 3 == 0, cnt);
			bus_write(m, a, $urandom, (i < 10) ? 4'hf : soc_pkg::strb_t'($urandom));
			bus_read(1 - m, mem_addr(i % 3 == 0, cnt));
		end
		report_test("memory");

		check_val("boot_addr", boot_addr, rst_boot_addr);
		bus_read(0, soc_pkg::CTRL_BASE + soc_pkg::REG_BOOT);
		bus_write(1, soc_pkg::CTRL_BASE + soc_pkg::REG_BOOT, $urandom, '1);
		check_val("boot_addr", boot_addr, sh_boot);
		bus_write(0, soc_pkg::CTRL_BASE + soc_pkg::REG_BOOT, 32'h0000_ab00, 4'b0010);
		check_val("boot_addr", boot_addr, sh_boot);
		bus_write(0, soc_pkg::CTRL_BASE + soc_pkg::REG_SRST, 32'hffff_fffe, '1);
		check_val("core_srst", soc_pkg::data_t'(core_srst), soc_pkg::data_t'(sh_srst));
		bus_read(1, soc_pkg::CTRL_BASE + soc_pkg::REG_SRST);
		bus_write(1, soc_pkg::CTRL_BASE + soc_pkg::REG_SRST, 32'h8000_0001, '1);
		check_val("core_srst", soc_pkg::data_t'(core_srst), soc_pkg::data_t'(sh_srst));
		bus_read(0, soc_pkg::CTRL_BASE + soc_pkg::REG_SRST);
		bus_read(0, soc_pkg::CTRL_BASE + soc_pkg::REG_SCRATCH);
		bus_write(0, soc_pkg::CTRL_BASE + soc_pkg::REG_SCRATCH, $urandom, '1);
		bus_read(1, soc_pkg::CTRL_BASE + soc_pkg::REG_SCRATCH);
		bus_write(1, soc_pkg::CTRL_BASE + soc_pkg::REG_SCRATCH, $urandom, 4'b0101);
		bus_read(0, soc_pkg::CTRL_BASE + soc_pkg::REG_SCRATCH);
		bus_write(0, soc_pkg::CTRL_BASE + 32'h10, $urandom, '1);
		bus_read(1, soc_pkg::CTRL_BASE + 32'h10);
		report_test("control");

		for (int k = 0; k < 7; k++) begin
			bus_write(k % 2, decerr_addr(k), $urandom, '1);
			bus_read((k + 1) % 2, decerr_addr(k));
		end
		bus_read(0, soc_pkg::CTRL_BASE + soc_pkg::REG_SCRATCH);
		bus_read(0, soc_pkg::CTRL_BASE + soc_pkg::REG_BOOT);
		bus_read(1, soc_pkg::CTRL_BASE + soc_pkg::REG_SRST);
		for (int w = 0; w < 4; w++) begin
			bus_read(w % 2, mem_addr(w % 2, w));
		end
		check_val("boot_addr", boot_addr, sh_boot);
		check_val("core_srst", soc_pkg::data_t'(core_srst), soc_pkg::data_t'(sh_srst));
		report_test("decode");

		bp_en[0] = 1'b1;
		bp_en[1] = 1'b1;
		fork
			random_traffic(0, 60);
			random_traffic(1, 60);
		join
		bp_en[0] = 1'b0;
		bp_en[1] = 1'b0;
		report_test("concurrent");

		fork
			bus_read(0, mem_addr(0, 10));
			begin
				repeat (2) @(posedge clk); // the read has been granted by this edge.
				pause_req <= 1'b1;
				cnt = 0;
				do begin
					@(posedge clk);
					cnt++;
				end while (pause_ack !== 1'b1);
			end
		join
		chk_cnt++;
		if (cnt - 1 < 3) begin
			$display("pause_ack rose %0d cycles after pause_req, too early", cnt - 1);
			err_cnt++;
		end
		fork
			bus_write(0, mem_addr(1, 20), 32'hcafe_f00d, '1);
			bus_read(1, mem_addr(0, 11));
			begin
				for (int i = 0; i < 50; i++) begin
					@(posedge clk);
					check_val("aw_ready[0]", soc_pkg::data_t'(aw_ready[0]), '0);
					check_val("w_ready[0]", soc_pkg::data_t'(w_ready[0]), '0);
					check_val("ar_ready[1]", soc_pkg::data_t'(ar_ready[1]), '0);
					check_val("pause_ack", soc_pkg::data_t'(pause_ack), 32'h1);
				end
				pause_req <= 1'b0;
				do @(posedge clk); while (pause_ack !== 1'b0);
			end
		join
		bus_read(1, mem_addr(1, 20));
		report_test("pause");

		repeat (2) @(posedge clk);
		if (exp_q0.size() + exp_q1.size() != 0) begin
			$display("responses were still outstanding at the end of the run");
			err_cnt++;
		end
		$display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// ==== soc_fabric.f ====
soc_pkg.sv
axil_if.sv
pause_seq.sv
axil_xbar.sv
axil_sram.sv
sys_ctrl.sv
soc_fabric.sv
tb_soc_fabric.sv

// ==== Bender.yml ====
package:
  name: soc_fabric

sources:
  - soc_pkg.sv
  - axil_if.sv
  - pause_seq.sv
  - axil_xbar.sv
  - axil_sram.sv
  - sys_ctrl.sv
  - soc_fabric.sv
  - target: test
    files:
      - tb_soc_fabric.sv
